/* project.f */
+incdir+design
design/axi_rd_pkg.sv
design/axi_read_engine.sv
design/axi_ar_arbiter.sv
design/axi_r_router.sv
design/axi_read_top.sv
testbench/tb_axi_mem_model.sv
testbench/tb_axi_read.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_axi_read
FILELIST = project.f
OBJDIR   = obj_dir
SOURCES  = $(shell grep -v '^+' $(FILELIST)) design/axi_rd_macros.svh

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "sim passed"

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* testbench/tb_axi_read.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_macros.svh"

module tb_axi_read;

	import axi_rd_pkg::*;

	localparam int NP = `AXI_RD_NUM_PORTS;

	typedef struct {
		int        port;
		addr_t     addr;
		cpu_size_t size;
		len_t      len;
		cpu_id_t   id;
		bit        conc; // Runs together with the next row
	} row_t;

	typedef struct {
		data_t   data;
		resp_t   resp;
		cpu_id_t id;
		logic    last;
	} beat_t;

	typedef struct {
		addr_t     addr;
		len_t      len;
		axi_size_t size;
		axi_id_t   id;
	} ar_t;

	logic          clk;
	logic          reset_n;
	logic [NP-1:0] cpu_ar_valid;
	logic [NP-1:0] cpu_ar_ready;
	addr_t         cpu_addr [NP];
	cpu_size_t     cpu_size [NP];
	len_t          cpu_len [NP];
	cpu_id_t       cpu_id [NP];
	logic [NP-1:0] cpu_r_valid;
	data_t         cpu_r_data [NP];
	resp_t         cpu_r_resp [NP];
	cpu_id_t       cpu_r_id [NP];
	logic [NP-1:0] cpu_r_last;

	logic      m_ar_valid;
	logic      m_ar_ready;
	addr_t     m_ar_addr;
	len_t      m_ar_len;
	axi_size_t m_ar_size;
	burst_t    m_ar_burst;
	axi_id_t   m_ar_id;
	logic      m_r_valid;
	logic      m_r_ready;
	data_t     m_r_data;
	resp_t     m_r_resp;
	logic      m_r_last;
	axi_id_t   m_r_id;

	row_t  rows [$];
	beat_t exp_q [NP][$]; // Beats still owed per port
	ar_t   ar_q [NP][$]; // Bus requests still owed per port
	int    errors;
	int    checks;
	int    cycles;
	int    limit;

	always #20 clk = ~clk;

	axi_read_top u_axi_read_top (
		.clk (clk), .reset_n (reset_n),
		.cpu_ar_valid_i (cpu_ar_valid), .cpu_ar_ready_o (cpu_ar_ready),
		.cpu_addr_i (cpu_addr), .cpu_size_i (cpu_size), .cpu_len_i (cpu_len),
		.cpu_id_i (cpu_id), .cpu_r_valid_o (cpu_r_valid), .cpu_r_data_o (cpu_r_data),
		.cpu_r_resp_o (cpu_r_resp), .cpu_r_id_o (cpu_r_id), .cpu_r_last_o (cpu_r_last),
		.m_ar_valid_o (m_ar_valid), .m_ar_ready_i (m_ar_ready), .m_ar_addr_o (m_ar_addr),
		.m_ar_len_o (m_ar_len), .m_ar_size_o (m_ar_size), .m_ar_burst_o (m_ar_burst),
		.m_ar_id_o (m_ar_id), .m_r_valid_i (m_r_valid), .m_r_ready_o (m_r_ready),
		.m_r_data_i (m_r_data), .m_r_resp_i (m_r_resp), .m_r_last_i (m_r_last),
		.m_r_id_i (m_r_id)
	);

	tb_axi_mem_model u_tb_axi_mem_model (
		.clk (clk), .reset_n (reset_n),
		.ar_valid_i (m_ar_valid), .ar_ready_o (m_ar_ready), .ar_addr_i (m_ar_addr),
		.ar_len_i (m_ar_len), .ar_id_i (m_ar_id),
		.r_valid_o (m_r_valid), .r_ready_i (m_r_ready), .r_data_o (m_r_data),
		.r_resp_o (m_r_resp), .r_last_o (m_r_last), .r_id_o (m_r_id)
	);

	// Slave word for beat k: beat address on top, its inverse below
	function automatic data_t bus_word(addr_t addr, int k);
		addr_t a;
		a = {addr[31:3], 3'b000} + addr_t'(8 * k);
		return {a, ~a};
	endfunction

	function automatic data_t keep_lanes(data_t word, addr_t addr, cpu_size_t size);
		data_t mask;
		int    lo;
		mask = '0;
		lo   = int'(addr[2:0]);
		for (int i = 0; i < (1 << size); i++) begin
			mask[(lo + i) * 8 +: 8] = 8'hff;
		end
		return word & mask;
	endfunction

	function automatic int outstanding();
		int n;
		n = 0;
		for (int p = 0; p < NP; p++) n += exp_q[p].size();
		return n;
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic add_row(input int port, input addr_t addr, input cpu_size_t size,
		input len_t len, input cpu_id_t id, input bit conc);
		rows.push_back('{port, addr, size, len, id, conc});
	endtask

	task automatic build_table();
		// Single beats, every size at every aligned offset
		add_row(0, 32'h0000_1000, 2'd0, 8'd0, 3'd0, 1'b0);
		add_row(1, 32'h0000_1001, 2'd0, 8'd0, 3'd1, 1'b0);
		add_row(0, 32'h0000_1002, 2'd0, 8'd0, 3'd2, 1'b0);
		add_row(1, 32'h0000_1003, 2'd0, 8'd0, 3'd3, 1'b0);
		add_row(0, 32'h0000_1004, 2'd0, 8'd0, 3'd4, 1'b0);
		add_row(1, 32'h0000_1005, 2'd0, 8'd0, 3'd5, 1'b0);
		add_row(0, 32'h0000_1006, 2'd0, 8'd0, 3'd6, 1'b0);
		add_row(1, 32'h0000_1007, 2'd0, 8'd0, 3'd7, 1'b0);
		add_row(0, 32'h0000_2000, 2'd1, 8'd0, 3'd1, 1'b0);
		add_row(1, 32'h0000_2002, 2'd1, 8'd0, 3'd2, 1'b0);
		add_row(0, 32'h0000_2004, 2'd1, 8'd0, 3'd3, 1'b0);
		add_row(1, 32'h0000_2006, 2'd1, 8'd0, 3'd4, 1'b0);
		add_row(0, 32'h0000_3000, 2'd2, 8'd0, 3'd5, 1'b0);
		add_row(1, 32'h0000_3004, 2'd2, 8'd0, 3'd6, 1'b0);
		add_row(0, 32'h0000_4008, 2'd3, 8'd0, 3'd7, 1'b0);
		// Bursts of 1 to 4 beats
		add_row(0, 32'h0000_5000, 2'd3, 8'd0, 3'd0, 1'b0);
		add_row(1, 32'h0000_5100, 2'd3, 8'd1, 3'd1, 1'b0);
		add_row(0, 32'h0000_5208, 2'd3, 8'd2, 3'd2, 1'b0);
		add_row(1, 32'h0000_5304, 2'd2, 8'd3, 3'd3, 1'b0);
		// Both ports in flight
		add_row(0, 32'h0000_6000, 2'd3, 8'd2, 3'd5, 1'b1);
		add_row(1, 32'h0000_700c, 2'd2, 8'd3, 3'd6, 1'b0);
		add_row(1, 32'h8000_0010, 2'd3, 8'd1, 3'd3, 1'b1);
		add_row(0, 32'h0000_0022, 2'd1, 8'd0, 3'd4, 1'b0);
		// Error region
		add_row(0, 32'h8000_1004, 2'd2, 8'd0, 3'd7, 1'b0);
		add_row(1, 32'h8000_2003, 2'd0, 8'd3, 3'd2, 1'b0);
	endtask

	task automatic issue(input row_t r);
		beat_t b;
		ar_t   a;
		for (int k = 0; k <= int'(r.len); k++) begin
			b.data = keep_lanes(bus_word(r.addr, k), r.addr, r.size);
			b.resp = r.addr[31] ? `AXI_RD_RESP_SLVERR : 2'b00;
			b.id   = r.id;
			b.last = (k == int'(r.len));
			exp_q[r.port].push_back(b);
		end
		// Word aligned, AXSIZE is log2 of the byte count, port index on top of the ID
		a.addr = {r.addr[31:3], 3'b000};
		a.len  = r.len;
		a.size = axi_size_t'($clog2(1 << int'(r.size)));
		a.id   = axi_id_t'((r.port << $bits(cpu_id_t)) | int'(r.id));
		ar_q[r.port].push_back(a);
		@(posedge clk);
		while (!cpu_ar_ready[r.port]) @(posedge clk);
		#2;
		cpu_ar_valid[r.port] = 1'b1;
		cpu_addr[r.port]     = r.addr;
		cpu_size[r.port]     = r.size;
		cpu_len[r.port]      = r.len;
		cpu_id[r.port]       = r.id;
		@(posedge clk); // Engine idle, so taken here
		#2;
		cpu_ar_valid[r.port] = 1'b0;
	endtask

	// Per-port beat checker
	always @(posedge clk) begin
		beat_t b;
		for (int p = 0; p < NP; p++) begin
			if (reset_n && cpu_r_valid[p]) begin
				if (exp_q[p].size() == 0) begin
					$display("Port %0d returned a beat that no request asked for", p);
					errors++;
				end else begin
					b = exp_q[p].pop_front();
					check($sformatf("cpu_r_data_o[%0d]", p), 64'(cpu_r_data[p]), 64'(b.data));
					check($sformatf("cpu_r_resp_o[%0d]", p), 64'(cpu_r_resp[p]), 64'(b.resp));
					check($sformatf("cpu_r_id_o[%0d]", p), 64'(cpu_r_id[p]), 64'(b.id));
					check($sformatf("cpu_r_last_o[%0d]", p), 64'(cpu_r_last[p]), 64'(b.last));
				end
			end
		end
	end

	// Shared AR channel at each handshake
	always @(posedge clk) begin
		ar_t a;
		int  p;
		if (reset_n && m_ar_valid && m_ar_ready) begin
			p = int'(m_ar_id[$bits(axi_id_t)-1]);
			if (ar_q[p].size() == 0) begin
				$display("Bus read request for port %0d that no test issued", p);
				errors++;
			end else begin
				a = ar_q[p].pop_front();
				check("m_ar_addr_o", 64'(m_ar_addr), 64'(a.addr));
				check("m_ar_len_o", 64'(m_ar_len), 64'(a.len));
				check("m_ar_size_o", 64'(m_ar_size), 64'(a.size));
				check("m_ar_burst_o", 64'(m_ar_burst), 64'(`AXI_RD_BURST_INCR));
				check("m_ar_id_o", 64'(m_ar_id), 64'(a.id));
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout after %0d cycles, %0d beats never arrived", cycles, outstanding());
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		int r;
		int n;
		int beats;
		int err_before;
		void'($urandom(23));
		clk          = 1'b0;
		reset_n      = 1'b0;
		cpu_ar_valid = '0;
		errors       = 0;
		checks       = 0;
		cycles       = 0;
		limit        = 0;
		for (int p = 0; p < NP; p++) begin
			cpu_addr[p] = '0;
			cpu_size[p] = '0;
			cpu_len[p]  = '0;
			cpu_id[p]   = '0;
		end
		build_table();
		beats = 0;
		foreach (rows[i]) beats += int'(rows[i].len) + 1;
		limit = 64 * beats + 100;

		repeat (3) @(posedge clk);
		#2;
		reset_n = 1'b1;
		@(posedge clk);
		check("cpu_ar_ready_o", 64'(cpu_ar_ready), 64'({NP{1'b1}}));
		check("cpu_r_valid_o", 64'(cpu_r_valid), 64'(0));
		$display("test reset: %s", errors == 0 ? "ok" : "FAIL");

		r = 0;
		while (r < rows.size()) begin
			err_before = errors;
			if (rows[r].conc && r + 1 < rows.size()) begin
				fork
					issue(rows[r]);
					issue(rows[r + 1]);
				join
				n = 2;
			end else begin
				issue(rows[r]);
				n = 1;
			end
			while (outstanding() != 0) @(posedge clk);
			for (int i = r; i < r + n; i++) begin
				$display("test %0d: port %0d addr 0x%h size %0d len %0d %s", i, rows[i].port,
					rows[i].addr, rows[i].size, rows[i].len,
					errors == err_before ? "ok" : "FAIL");
			end
			r += n;
		end

		$display("%0d tests, %0d checks, %0d errors", rows.size() + 1, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/tb_axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_macros.svh"

module tb_axi_mem_model (
	input  wire                 clk,
	input  wire                 reset_n,
	// AR slave
	input  wire                 ar_valid_i,
	output logic                ar_ready_o,
	input  axi_rd_pkg::addr_t   ar_addr_i,
	input  axi_rd_pkg::len_t    ar_len_i,
	input  axi_rd_pkg::axi_id_t ar_id_i,
	// R slave
	output logic                r_valid_o,
	input  wire                 r_ready_i,
	output axi_rd_pkg::data_t   r_data_o,
	output axi_rd_pkg::resp_t   r_resp_o,
	output logic                r_last_o,
	output axi_rd_pkg::axi_id_t r_id_o
);

	import axi_rd_pkg::*;

	addr_t   q_addr [$]; // Accepted bursts, oldest first
	len_t    q_len [$];
	axi_id_t q_id [$];
	int      beat;

	initial begin
		ar_ready_o = 1'b0;
		r_valid_o  = 1'b0;
		r_data_o   = '0;
		r_resp_o   = '0;
		r_last_o   = 1'b0;
		r_id_o     = '0;
		beat       = 0;
	end

	always @(posedge clk) begin
		logic  r_hs;
		addr_t beat_addr;
		r_hs = r_valid_o && r_ready_i;
		if (!reset_n) begin
			q_addr.delete();
			q_len.delete();
			q_id.delete();
			beat = 0;
			#2;
			ar_ready_o = 1'b0;
			r_valid_o  = 1'b0;
		end else begin
			if (ar_valid_i && ar_ready_o) begin
				q_addr.push_back(ar_addr_i);
				q_len.push_back(ar_len_i);
				q_id.push_back(ar_id_i);
			end
			if (r_hs) begin
				if (r_last_o) begin
					void'(q_addr.pop_front());
					void'(q_len.pop_front());
					void'(q_id.pop_front());
					beat = 0;
				end else begin
					beat++;
				end
			end
			#2;
			ar_ready_o = ($urandom % 4) != 0;
			if (r_valid_o && !r_hs) begin
				r_valid_o = 1'b1; // Beat waits for ready
			end else if (q_addr.size() != 0 && ($urandom % 4) != 0) begin
				beat_addr = q_addr[0] + addr_t'(beat * 8);
				r_valid_o = 1'b1;
				r_data_o  = {beat_addr, ~beat_addr};
				r_resp_o  = q_addr[0][31] ? `AXI_RD_RESP_SLVERR : 2'b00; // Upper half errors
				r_last_o  = (beat == int'(q_len[0]));
				r_id_o    = q_id[0];
			end else begin
				r_valid_o = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* design/axi_read_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_macros.svh"

module axi_read_top (
	input  wire                              clk,
	input  wire                              reset_n,
	// CPU ports
	input  wire [`AXI_RD_NUM_PORTS-1:0]      cpu_ar_valid_i,
	output logic [`AXI_RD_NUM_PORTS-1:0]     cpu_ar_ready_o,
	input  axi_rd_pkg::addr_t                cpu_addr_i [`AXI_RD_NUM_PORTS],
	input  axi_rd_pkg::cpu_size_t            cpu_size_i [`AXI_RD_NUM_PORTS],
	input  axi_rd_pkg::len_t                 cpu_len_i  [`AXI_RD_NUM_PORTS],
	input  axi_rd_pkg::cpu_id_t              cpu_id_i   [`AXI_RD_NUM_PORTS],
	output logic [`AXI_RD_NUM_PORTS-1:0]     cpu_r_valid_o,
	output axi_rd_pkg::data_t                cpu_r_data_o [`AXI_RD_NUM_PORTS],
	output axi_rd_pkg::resp_t                cpu_r_resp_o [`AXI_RD_NUM_PORTS],
	output axi_rd_pkg::cpu_id_t              cpu_r_id_o   [`AXI_RD_NUM_PORTS],
	output logic [`AXI_RD_NUM_PORTS-1:0]     cpu_r_last_o,
	// AXI master AR
	output logic                             m_ar_valid_o,
	input  wire                              m_ar_ready_i,
	output axi_rd_pkg::addr_t                m_ar_addr_o,
	output axi_rd_pkg::len_t                 m_ar_len_o,
	output axi_rd_pkg::axi_size_t            m_ar_size_o,
	output axi_rd_pkg::burst_t               m_ar_burst_o,
	output axi_rd_pkg::axi_id_t              m_ar_id_o,
	// AXI master R
	input  wire                              m_r_valid_i,
	output logic                             m_r_ready_o,
	input  axi_rd_pkg::data_t                m_r_data_i,
	input  axi_rd_pkg::resp_t                m_r_resp_i,
	input  wire                              m_r_last_i,
	input  axi_rd_pkg::axi_id_t              m_r_id_i
);

	import axi_rd_pkg::*;

	logic [`AXI_RD_NUM_PORTS-1:0] eng_ar_valid;
	logic [`AXI_RD_NUM_PORTS-1:0] eng_ar_ready;
	addr_t                        eng_ar_addr [`AXI_RD_NUM_PORTS];
	len_t                         eng_ar_len  [`AXI_RD_NUM_PORTS];
	axi_size_t                    eng_ar_size [`AXI_RD_NUM_PORTS];
	cpu_id_t                      eng_ar_id   [`AXI_RD_NUM_PORTS];
	logic [`AXI_RD_NUM_PORTS-1:0] eng_r_valid;
	logic [`AXI_RD_NUM_PORTS-1:0] eng_r_ready;

	for (genvar g = 0; g < `AXI_RD_NUM_PORTS; g++) begin : g_engine
		axi_read_engine u_axi_read_engine (
			.clk            (clk),
			.reset_n        (reset_n),
			.cpu_ar_valid_i (cpu_ar_valid_i[g]),
			.cpu_ar_ready_o (cpu_ar_ready_o[g]),
			.cpu_addr_i     (cpu_addr_i[g]),
			.cpu_size_i     (cpu_size_i[g]),
			.cpu_len_i      (cpu_len_i[g]),
			.cpu_id_i       (cpu_id_i[g]),
			.cpu_r_valid_o  (cpu_r_valid_o[g]),
			.cpu_r_data_o   (cpu_r_data_o[g]),
			.cpu_r_resp_o   (cpu_r_resp_o[g]),
			.cpu_r_id_o     (cpu_r_id_o[g]),
			.cpu_r_last_o   (cpu_r_last_o[g]),
			.ar_valid_o     (eng_ar_valid[g]),
			.ar_ready_i     (eng_ar_ready[g]),
			.ar_addr_o      (eng_ar_addr[g]),
			.ar_len_o       (eng_ar_len[g]),
			.ar_size_o      (eng_ar_size[g]),
			.ar_id_o        (eng_ar_id[g]),
			.r_valid_i      (eng_r_valid[g]),
			.r_ready_o      (eng_r_ready[g]),
			.r_data_i       (m_r_data_i), // Payload broadcast
			.r_resp_i       (m_r_resp_i),
			.r_last_i       (m_r_last_i)
		);
	end

	axi_ar_arbiter u_axi_ar_arbiter (
		.clk            (clk),
		.reset_n        (reset_n),
		.eng_ar_valid_i (eng_ar_valid),
		.eng_ar_ready_o (eng_ar_ready),
		.eng_ar_addr_i  (eng_ar_addr),
		.eng_ar_len_i   (eng_ar_len),
		.eng_ar_size_i  (eng_ar_size),
		.eng_ar_id_i    (eng_ar_id),
		.m_ar_valid_o   (m_ar_valid_o),
		.m_ar_ready_i   (m_ar_ready_i),
		.m_ar_addr_o    (m_ar_addr_o),
		.m_ar_len_o     (m_ar_len_o),
		.m_ar_size_o    (m_ar_size_o),
		.m_ar_id_o      (m_ar_id_o),
		.m_ar_burst_o   (m_ar_burst_o)
	);

	axi_r_router u_axi_r_router (
		.m_r_valid_i   (m_r_valid_i),
		.m_r_ready_o   (m_r_ready_o),
		.m_r_id_i      (m_r_id_i),
		.eng_r_valid_o (eng_r_valid),
		.eng_r_ready_i (eng_r_ready)
	);

endmodule

`default_nettype wire

/* design/axi_r_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_macros.svh"

module axi_r_router (
	// Shared R handshake
	input  wire                          m_r_valid_i,
	output logic                         m_r_ready_o,
	input  axi_rd_pkg::axi_id_t          m_r_id_i,
	// Per-engine R handshake
	output logic [`AXI_RD_NUM_PORTS-1:0] eng_r_valid_o,
	input  wire [`AXI_RD_NUM_PORTS-1:0]  eng_r_ready_i
);

	import axi_rd_pkg::*;

	port_idx_t dest;

	// Upper ID bits name the engine
	assign dest = m_r_id_i[$bits(axi_id_t)-1 -: $bits(port_idx_t)];

	always_comb begin
		for (int i = 0; i < `AXI_RD_NUM_PORTS; i++) begin
			eng_r_valid_o[i] = m_r_valid_i && (dest == port_idx_t'(i));
		end
	end

	// Bus sees only the addressed engine
	assign m_r_ready_o = eng_r_ready_i[dest];

endmodule

`default_nettype wire

/* design/axi_ar_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "axi_rd_macros.svh"

module axi_ar_arbiter (
	input  wire                              clk,
	input  wire                              reset_n,
	// Engine AR channels
	input  wire [`AXI_RD_NUM_PORTS-1:0]      eng_ar_valid_i,
	output logic [`AXI_RD_NUM_PORTS-1:0]     eng_ar_ready_o,
	input  axi_rd_pkg::addr_t                eng_ar_addr_i [`AXI_RD_NUM_PORTS],
	input  axi_rd_pkg::len_t                 eng_ar_len_i  [`AXI_RD_NUM_PORTS],
	input  axi_rd_pkg::axi_size_t            eng_ar_size_i [`AXI_RD_NUM_PORTS],
	input  axi_rd_pkg::cpu_id_t              eng_ar_id_i   [`AXI_RD_NUM_PORTS],
	// Shared AR channel
	output logic                             m_ar_valid_o,
	input  wire                              m_ar_ready_i,
	output axi_rd_pkg::addr_t                m_ar_addr_o,
	output axi_rd_pkg::len_t                 m_ar_len_o,
	output axi_rd_pkg::axi_size_t            m_ar_size_o,
	output axi_rd_pkg::axi_id_t              m_ar_id_o,
	output axi_rd_pkg::burst_t               m_ar_burst_o
);

	import axi_rd_pkg::*;

	port_idx_t last_q; // Last port served
	logic      lock_q;
	port_idx_t lock_idx_q;

	port_idx_t pick;
	logic      found;
	port_idx_t sel;

	// Search starts one past the last winner
	always_comb begin
		port_idx_t cand;
		pick  = last_q;
		found = 1'b0;
		for (int k = 1; k <= `AXI_RD_NUM_PORTS; k++) begin
			cand = port_idx_t'((int'(last_q) + k) % `AXI_RD_NUM_PORTS);
			if (!found && eng_ar_valid_i[cand]) begin
				pick  = cand;
				found = 1'b1;
			end
		end
	end

	assign sel = lock_q ? lock_idx_q : pick;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			last_q <= port_idx_t'(`AXI_RD_NUM_PORTS - 1); // Port 0 goes first
			lock_q <= 1'b0;
		end else if (m_ar_valid_o && m_ar_ready_i) begin
			last_q <= sel;
			lock_q <= 1'b0;
		end else if (m_ar_valid_o) begin
			lock_q <= 1'b1; // Stalled, keep this winner
		end
	end

	always_ff @(posedge clk) begin
		if (m_ar_valid_o && !lock_q) lock_idx_q <= sel;
	end

	always_comb begin
		for (int i = 0; i < `AXI_RD_NUM_PORTS; i++) begin
			eng_ar_ready_o[i] = m_ar_ready_i && (sel == port_idx_t'(i));
		end
	end

	assign m_ar_valid_o = eng_ar_valid_i[sel];
	assign m_ar_addr_o  = eng_ar_addr_i[sel];
	assign m_ar_len_o   = eng_ar_len_i[sel];
	assign m_ar_size_o  = eng_ar_size_i[sel];
	assign m_ar_id_o    = {sel, eng_ar_id_i[sel]}; // Port index on top
	assign m_ar_burst_o = `AXI_RD_BURST_INCR;

endmodule

`default_nettype wire

/* design/axi_read_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_engine (
	input  wire                   clk,
	input  wire                   reset_n,
	// CPU request
	input  wire                   cpu_ar_valid_i,
	output logic                  cpu_ar_ready_o,
	input  axi_rd_pkg::addr_t     cpu_addr_i,
	input  axi_rd_pkg::cpu_size_t cpu_size_i,
	input  axi_rd_pkg::len_t      cpu_len_i,
	input  axi_rd_pkg::cpu_id_t   cpu_id_i,
	// CPU read data, no back-pressure
	output logic                  cpu_r_valid_o,
	output axi_rd_pkg::data_t     cpu_r_data_o,
	output axi_rd_pkg::resp_t     cpu_r_resp_o,
	output axi_rd_pkg::cpu_id_t   cpu_r_id_o,
	output logic                  cpu_r_last_o,
	// AXI AR
	output logic                  ar_valid_o,
	input  wire                   ar_ready_i,
	output axi_rd_pkg::addr_t     ar_addr_o,
	output axi_rd_pkg::len_t      ar_len_o,
	output axi_rd_pkg::axi_size_t ar_size_o,
	output axi_rd_pkg::cpu_id_t   ar_id_o,
	// AXI R
	input  wire                   r_valid_i,
	output logic                  r_ready_o,
	input  axi_rd_pkg::data_t     r_data_i,
	input  axi_rd_pkg::resp_t     r_resp_i,
	input  wire                   r_last_i
);

	import axi_rd_pkg::*;

	read_state_e state_q;
	read_state_e state_d;

	addr_t     addr_q;
	cpu_size_t size_q;
	len_t      len_q;
	cpu_id_t   id_q;

	logic req_hs;
	logic ar_hs;
	logic r_hs;

	logic [3:0] byte_lo; // First kept lane
	logic [3:0] byte_hi; // One past the last kept lane
	data_t      lane_mask;

	assign cpu_ar_ready_o = (state_q == READ_IDLE);
	assign ar_valid_o     = (state_q == READ_ADDR);
	assign r_ready_o      = (state_q == READ_DATA);

	assign req_hs = cpu_ar_valid_i & cpu_ar_ready_o;
	assign ar_hs  = ar_valid_o & ar_ready_i;
	assign r_hs   = r_valid_i & r_ready_o;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q <= READ_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			READ_IDLE: if (req_hs) state_d = READ_ADDR;
			READ_ADDR: if (ar_hs) state_d = READ_DATA;
			READ_DATA: if (r_hs && r_last_i) state_d = READ_IDLE;
			default:   state_d = READ_IDLE;
		endcase
	end

	// Request fields held for the whole burst
	always_ff @(posedge clk) begin
		if (req_hs) begin
			addr_q <= cpu_addr_i;
			size_q <= cpu_size_i;
			len_q  <= cpu_len_i;
			id_q   <= cpu_id_i;
		end
	end

	assign ar_addr_o = {addr_q[$bits(addr_t)-1:3], 3'b000}; // Word aligned
	assign ar_len_o  = len_q;
	assign ar_size_o = axi_size_t'(size_q); // log2 of the byte count
	assign ar_id_o   = id_q;

	assign byte_lo = {1'b0, addr_q[2:0]};
	assign byte_hi = byte_lo + (4'd1 << size_q);

	always_comb begin
		for (int i = 0; i < $bits(data_t) / 8; i++) begin
			lane_mask[i*8 +: 8] = (4'(i) >= byte_lo && 4'(i) < byte_hi) ? 8'hff : 8'h00;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cpu_r_valid_o <= 1'b0;
		end else begin
			cpu_r_valid_o <= r_hs; // One pulse per beat
		end
	end

	always_ff @(posedge clk) begin
		if (r_hs) begin
			cpu_r_data_o <= r_data_i & lane_mask;
			cpu_r_resp_o <= r_resp_i;
			cpu_r_id_o   <= id_q;
			cpu_r_last_o <= r_last_i;
		end
	end

endmodule

`default_nettype wire

/* design/axi_rd_pkg.sv */
`default_nettype none

`include "axi_rd_macros.svh"

package axi_rd_pkg;

	typedef logic [`AXI_RD_ADDR_WIDTH-1:0] addr_t;
	typedef logic [`AXI_RD_DATA_WIDTH-1:0] data_t;
	typedef logic [`AXI_RD_ID_WIDTH-1:0] axi_id_t; // Top bit selects the engine
	typedef logic [`AXI_RD_CPU_ID_WIDTH-1:0] cpu_id_t;
	typedef logic [`AXI_RD_LEN_WIDTH-1:0] len_t; // Beats minus one

	typedef logic [`AXI_RD_CPU_SIZE_WIDTH-1:0] cpu_size_t;
	typedef logic [`AXI_RD_SIZE_WIDTH-1:0] axi_size_t;
	typedef logic [`AXI_RD_RESP_WIDTH-1:0] resp_t;
	typedef logic [`AXI_RD_BURST_WIDTH-1:0] burst_t;

	typedef logic [$clog2(`AXI_RD_NUM_PORTS)-1:0] port_idx_t;

	// Engine FSM
	typedef enum logic [1:0] {
		READ_IDLE,
		READ_ADDR,
		READ_DATA
	} read_state_e;

endpackage

`default_nettype wire

/* design/axi_rd_macros.svh */
`ifndef AXI_RD_MACROS_SVH
`define AXI_RD_MACROS_SVH

// Bus widths
`define AXI_RD_DATA_WIDTH 64
`define AXI_RD_ADDR_WIDTH 32
`define AXI_RD_LEN_WIDTH 8
`define AXI_RD_SIZE_WIDTH 3
`define AXI_RD_RESP_WIDTH 2
`define AXI_RD_BURST_WIDTH 2

// Bus ID is {port index, cpu id}
`define AXI_RD_ID_WIDTH 4
`define AXI_RD_CPU_ID_WIDTH 3

// 0:1B 1:2B 2:4B 3:8B
`define AXI_RD_CPU_SIZE_WIDTH 2

// Engines on the shared port
`define AXI_RD_NUM_PORTS 2

// Encodings
`define AXI_RD_BURST_INCR 2'b01
`define AXI_RD_RESP_SLVERR 2'b10

`endif
